/* hdl/axi_bus_pkg.sv */
package axi_bus_pkg;

	// widths seen on the AXI side
	typedef logic [31:0] addr_t;   // byte address
	typedef logic [31:0] data_t;   // one bus word
	typedef logic [3:0]  strb_t;   // byte lanes of a word
	typedef logic [3:0]  axi_id_t;
	typedef logic [3:0]  len_t;    // beats minus one
	typedef logic [2:0]  size_t;   // log2 bytes per beat
	typedef logic [1:0]  burst_t;

	localparam burst_t BURST_FIXED = 2'd0;
	localparam burst_t BURST_INCR  = 2'd1;

	// shared by AR and AW
	typedef struct packed {
		axi_id_t id;
		addr_t   addr;
		len_t    len;
		size_t   size;
		burst_t  burst;
	} ax_req_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
		logic  last;
	} w_beat_t;

	typedef struct packed {
		axi_id_t id;
		data_t   data;
		logic    last;
	} r_beat_t;

	localparam axi_id_t ID_INST = 4'd0;   // icache reads
	localparam axi_id_t ID_DATA = 4'd1;   // dcache reads and every write

endpackage

/* hdl/cache_port_pkg.sv */
package cache_port_pkg;

	// read request from either cache
	typedef struct packed {
		axi_bus_pkg::addr_t addr;
		axi_bus_pkg::size_t size;
		logic               uncached;   // single beat, fixed burst
	} rd_req_t;

	// write request from the dcache
	typedef struct packed {
		axi_bus_pkg::addr_t addr;
		axi_bus_pkg::size_t size;
		axi_bus_pkg::strb_t strb;
		logic               uncached;
		axi_bus_pkg::data_t word;   // data of an uncached write
	} wr_req_t;

	// one returned read word
	typedef struct packed {
		axi_bus_pkg::data_t data;
		logic               last;
	} ret_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_e;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_e;

endpackage

/* hdl/axi_read_engine.sv */
`timescale 1ns/1ps

module axi_read_engine #(
	parameter int BURST_BEATS = 16
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ic_rd_req,
	input  cache_port_pkg::rd_req_t ic_rd,
	output logic                    ic_rd_rdy,
	output logic                    ic_ret_valid,
	output cache_port_pkg::ret_t    ic_ret,
	input  logic                    dc_rd_req,
	input  cache_port_pkg::rd_req_t dc_rd,
	output logic                    dc_rd_rdy,
	output logic                    dc_ret_valid,
	output cache_port_pkg::ret_t    dc_ret,
	input  logic                    write_busy,
	output axi_bus_pkg::ax_req_t    ar,
	output logic                    arvalid,
	input  logic                    arready,
	input  axi_bus_pkg::r_beat_t    r,
	input  logic                    rvalid
);
	localparam axi_bus_pkg::len_t LINE_LEN = axi_bus_pkg::len_t'(BURST_BEATS - 1);

	cache_port_pkg::rd_state_e state;
	cache_port_pkg::rd_state_e state_nxt;
	logic ic_acc;
	logic dc_acc;
	logic r_beat;

	function automatic axi_bus_pkg::ax_req_t make_ar(input cache_port_pkg::rd_req_t req,
			input axi_bus_pkg::axi_id_t id);
		axi_bus_pkg::ax_req_t ax;
		ax.id    = id;
		ax.addr  = req.addr;
		ax.size  = req.size;
		ax.len   = req.uncached ? '0 : LINE_LEN;
		ax.burst = req.uncached ? axi_bus_pkg::BURST_FIXED : axi_bus_pkg::BURST_INCR;
		return ax;
	endfunction

	// icache wins a same-cycle tie
	assign ic_rd_rdy = (state == cache_port_pkg::RD_IDLE) && !write_busy;
	assign dc_rd_rdy = ic_rd_rdy && !ic_rd_req;
	assign ic_acc    = ic_rd_req && ic_rd_rdy;
	assign dc_acc    = dc_rd_req && dc_rd_rdy;

	assign arvalid = (state == cache_port_pkg::RD_ADDR);
	assign r_beat  = rvalid;   // every R beat is passed straight on

	// steer by the returned ID
	assign ic_ret_valid = r_beat && (r.id == axi_bus_pkg::ID_INST);
	assign dc_ret_valid = r_beat && (r.id == axi_bus_pkg::ID_DATA);
	assign ic_ret       = '{data: r.data, last: r.last};
	assign dc_ret       = '{data: r.data, last: r.last};

	always_comb begin
		state_nxt = state;
		case (state)
			cache_port_pkg::RD_IDLE: if (ic_acc || dc_acc) state_nxt = cache_port_pkg::RD_ADDR;
			cache_port_pkg::RD_ADDR: if (arready) state_nxt = cache_port_pkg::RD_DATA;
			cache_port_pkg::RD_DATA: if (rvalid && r.last) state_nxt = cache_port_pkg::RD_IDLE;
			default:                 state_nxt = cache_port_pkg::RD_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= cache_port_pkg::RD_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// address held from acceptance until the AR transfer
	always_ff @(posedge clk) begin
		if (ic_acc) begin
			ar <= make_ar(ic_rd, axi_bus_pkg::ID_INST);
		end else if (dc_acc) begin
			ar <= make_ar(dc_rd, axi_bus_pkg::ID_DATA);
		end
	end

	ar_hold: assert property (@(posedge clk) disable iff (!rst)
		arvalid && !arready |=> arvalid && $stable(ar));

	ret_in_data: assert property (@(posedge clk) disable iff (!rst)
		(ic_ret_valid || dc_ret_valid) |-> state == cache_port_pkg::RD_DATA);

endmodule

/* hdl/axi_write_engine.sv */
`timescale 1ns/1ps

module axi_write_engine #(
	parameter int BURST_BEATS = 16
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   dc_wr_req,
	input  cache_port_pkg::wr_req_t                dc_wr,
	input  axi_bus_pkg::data_t [BURST_BEATS-1:0]   dc_wr_line,
	output logic                                   dc_wr_rdy,
	output logic                                   write_busy,
	output axi_bus_pkg::ax_req_t                   aw,
	output logic                                   awvalid,
	input  logic                                   awready,
	output axi_bus_pkg::w_beat_t                   w,
	output logic                                   wvalid,
	input  logic                                   wready,
	input  logic                                   bvalid
);
	localparam int CNT_W = $clog2(BURST_BEATS + 1);
	localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(BURST_BEATS - 1);
	localparam axi_bus_pkg::len_t LINE_LEN = axi_bus_pkg::len_t'(BURST_BEATS - 1);

	cache_port_pkg::wr_state_e state;
	cache_port_pkg::wr_state_e state_nxt;
	cache_port_pkg::wr_req_t req_q;                   // registered request
	axi_bus_pkg::data_t [BURST_BEATS-1:0] line_q;     // line buffer with word 0 out next
	logic [CNT_W-1:0] beat_cnt;
	logic wr_acc;
	logic w_xfer;
	logic last_beat;

	assign dc_wr_rdy  = (state == cache_port_pkg::WR_IDLE);
	assign wr_acc     = dc_wr_req && dc_wr_rdy;
	assign write_busy = (state != cache_port_pkg::WR_IDLE);   // drops the cycle after bvalid

	assign awvalid   = (state == cache_port_pkg::WR_ADDR);
	assign wvalid    = (state == cache_port_pkg::WR_DATA);
	assign w_xfer    = wvalid && wready;
	assign last_beat = req_q.uncached || (beat_cnt == LAST_BEAT);

	always_comb begin
		aw.id    = axi_bus_pkg::ID_DATA;
		aw.addr  = req_q.addr;
		aw.size  = req_q.size;
		aw.len   = req_q.uncached ? '0 : LINE_LEN;
		aw.burst = req_q.uncached ? axi_bus_pkg::BURST_FIXED : axi_bus_pkg::BURST_INCR;
	end

	always_comb begin
		w.data = req_q.uncached ? req_q.word : line_q[0];
		w.strb = req_q.uncached ? req_q.strb : '1;   // a line writes every byte
		w.last = wvalid && last_beat;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			cache_port_pkg::WR_IDLE: if (wr_acc) state_nxt = cache_port_pkg::WR_ADDR;
			cache_port_pkg::WR_ADDR: if (awready) state_nxt = cache_port_pkg::WR_DATA;
			cache_port_pkg::WR_DATA: if (wready && last_beat) state_nxt = cache_port_pkg::WR_RESP;
			cache_port_pkg::WR_RESP: if (bvalid) state_nxt = cache_port_pkg::WR_IDLE;
			default:                 state_nxt = cache_port_pkg::WR_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state    <= cache_port_pkg::WR_IDLE;
			beat_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (wr_acc) begin
				beat_cnt <= '0;
			end else if (w_xfer) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_acc) begin
			req_q  <= dc_wr;
			line_q <= dc_wr_line;
		end else if (w_xfer) begin
			line_q <= {axi_bus_pkg::data_t'(0), line_q[BURST_BEATS-1:1]};   // next word down
		end
	end

	// last only on the closing beat
	wlast_final: assert property (@(posedge clk) disable iff (!rst)
		w.last |-> wvalid && (req_q.uncached ? beat_cnt == '0 : beat_cnt == LAST_BEAT));

	cnt_bound: assert property (@(posedge clk) disable iff (!rst)
		beat_cnt <= CNT_W'(BURST_BEATS));

endmodule

/* hdl/cache_axi_bridge.sv */
`timescale 1ns/1ps

module cache_axi_bridge #(
	parameter int BURST_BEATS = 16
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   ic_rd_req,
	input  cache_port_pkg::rd_req_t                ic_rd,
	output logic                                   ic_rd_rdy,
	output logic                                   ic_ret_valid,
	output cache_port_pkg::ret_t                   ic_ret,
	input  logic                                   dc_rd_req,
	input  cache_port_pkg::rd_req_t                dc_rd,
	output logic                                   dc_rd_rdy,
	output logic                                   dc_ret_valid,
	output cache_port_pkg::ret_t                   dc_ret,
	input  logic                                   dc_wr_req,
	input  cache_port_pkg::wr_req_t                dc_wr,
	input  axi_bus_pkg::data_t [BURST_BEATS-1:0]   dc_wr_line,
	output logic                                   dc_wr_rdy,
	output axi_bus_pkg::ax_req_t                   ar,
	output logic                                   arvalid,
	input  logic                                   arready,
	input  axi_bus_pkg::r_beat_t                   r,
	input  logic                                   rvalid,
	output axi_bus_pkg::ax_req_t                   aw,
	output logic                                   awvalid,
	input  logic                                   awready,
	output axi_bus_pkg::w_beat_t                   w,
	output logic                                   wvalid,
	input  logic                                   wready,
	input  logic                                   bvalid
);
	logic write_busy;   // holds reads off while a write is open

	axi_read_engine #(
		.BURST_BEATS(BURST_BEATS)
	) u_rd (
		.clk(clk),
		.rst(rst),
		.ic_rd_req(ic_rd_req),
		.ic_rd(ic_rd),
		.ic_rd_rdy(ic_rd_rdy),
		.ic_ret_valid(ic_ret_valid),
		.ic_ret(ic_ret),
		.dc_rd_req(dc_rd_req),
		.dc_rd(dc_rd),
		.dc_rd_rdy(dc_rd_rdy),
		.dc_ret_valid(dc_ret_valid),
		.dc_ret(dc_ret),
		.write_busy(write_busy),
		.ar(ar),
		.arvalid(arvalid),
		.arready(arready),
		.r(r),
		.rvalid(rvalid)
	);

	axi_write_engine #(
		.BURST_BEATS(BURST_BEATS)
	) u_wr (
		.clk(clk),
		.rst(rst),
		.dc_wr_req(dc_wr_req),
		.dc_wr(dc_wr),
		.dc_wr_line(dc_wr_line),
		.dc_wr_rdy(dc_wr_rdy),
		.write_busy(write_busy),
		.aw(aw),
		.awvalid(awvalid),
		.awready(awready),
		.w(w),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid)
	);

endmodule

/* verif/axi_slave_model.sv */
`timescale 1ns/1ps

module axi_slave_model #(
	parameter int          BURST_BEATS = 16,
	parameter logic [31:0] SEED        = 32'hc524cb96
) (
	input  logic                 clk,
	input  logic                 rst,
	input  axi_bus_pkg::ax_req_t ar,
	input  logic                 arvalid,
	output logic                 arready,
	output axi_bus_pkg::r_beat_t r,
	output logic                 rvalid,
	input  axi_bus_pkg::ax_req_t aw,
	input  logic                 awvalid,
	output logic                 awready,
	input  axi_bus_pkg::w_beat_t w,
	input  logic                 wvalid,
	output logic                 wready,
	output logic                 bvalid,
	output logic                 overrun   // sticky, a write burst ran past one line
);
	axi_bus_pkg::data_t   mem [axi_bus_pkg::addr_t];   // written words only
	axi_bus_pkg::ax_req_t rd_q;
	axi_bus_pkg::len_t    rd_left;
	axi_bus_pkg::addr_t   wr_addr;
	axi_bus_pkg::burst_t  wr_burst;
	logic                 rd_act;
	int                   wr_cnt;

	// untouched words read back as address xor 32'h5a5a0000
	function automatic axi_bus_pkg::data_t load(input axi_bus_pkg::addr_t a);
		axi_bus_pkg::addr_t wa;
		wa = {a[31:2], 2'b00};
		if (mem.exists(wa)) return mem[wa];
		return wa ^ 32'h5a5a0000;
	endfunction

	task automatic store(input axi_bus_pkg::addr_t a, input axi_bus_pkg::data_t d,
			input axi_bus_pkg::strb_t s);
		axi_bus_pkg::data_t word;
		word = load(a);
		for (int b = 0; b < 4; b++) begin
			if (s[b]) word[8*b +: 8] = d[8*b +: 8];
		end
		mem[{a[31:2], 2'b00}] = word;
	endtask

	// ready stalls, R and B are never held back
	initial begin
		void'($urandom(SEED));
		arready = 1'b0;
		awready = 1'b0;
		wready  = 1'b0;
		forever begin
			@(posedge clk);
			arready <= ($urandom % 4) != 0;
			awready <= ($urandom % 4) != 0;
			wready  <= ($urandom % 3) != 0;
		end
	end

	always @(posedge clk) begin
		if (!rst) begin
			rd_act  <= 1'b0;
			rvalid  <= 1'b0;
			bvalid  <= 1'b0;
			wr_cnt  <= 0;
			overrun <= 1'b0;
		end else begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
			if (arvalid && arready) begin
				rd_act  <= 1'b1;
				rd_q    <= ar;
				rd_left <= ar.len;
			end else if (rd_act) begin
				rvalid <= 1'b1;
				r      <= '{id: rd_q.id, data: load(rd_q.addr), last: rd_left == '0};
				if (rd_q.burst == axi_bus_pkg::BURST_INCR) rd_q.addr <= rd_q.addr + 32'd4;
				rd_left <= rd_left - 1'b1;
				if (rd_left == '0) rd_act <= 1'b0;
			end
			if (awvalid && awready) begin
				wr_addr  <= aw.addr;
				wr_burst <= aw.burst;
				wr_cnt   <= 0;
			end
			if (wvalid && wready) begin
				store(wr_addr, w.data, w.strb);
				if (wr_burst == axi_bus_pkg::BURST_INCR) wr_addr <= wr_addr + 32'd4;
				wr_cnt <= wr_cnt + 1;
				if (wr_cnt >= BURST_BEATS) overrun <= 1'b1;
				if (w.last) bvalid <= 1'b1;   // response one cycle after the last beat
			end
		end
	end

endmodule

/* verif/tb_cache_axi_bridge.sv */
`timescale 1ns/1ps

module tb_cache_axi_bridge;
	localparam int BURST_BEATS = 16;
	localparam int N_ROWS      = 6;
	localparam int WATCHDOG_NS = N_ROWS * (BURST_BEATS * 8 + 40) * 4;

	typedef enum int {T_IC_READ, T_DC_READ, T_READ_TIE, T_LINE_WRITE, T_WORD_WRITE,
		T_WRITE_HOLD} kind_e;

	typedef struct {
		string               name;
		kind_e               kind;
		axi_bus_pkg::addr_t  addr;
		axi_bus_pkg::addr_t  addr2;   // data-side address of the tie row
		logic                unc;
		axi_bus_pkg::data_t  data;
		axi_bus_pkg::strb_t  strb;
	} row_t;

	logic clk;
	logic rst;
	logic ic_rd_req;
	logic dc_rd_req;
	logic dc_wr_req;
	logic ic_rd_rdy;
	logic dc_rd_rdy;
	logic dc_wr_rdy;
	logic ic_ret_valid;
	logic dc_ret_valid;
	logic arvalid, arready, rvalid, awvalid, awready, wvalid, wready, bvalid;
	logic overrun;
	cache_port_pkg::rd_req_t ic_rd;
	cache_port_pkg::rd_req_t dc_rd;
	cache_port_pkg::wr_req_t dc_wr;
	cache_port_pkg::ret_t    ic_ret;
	cache_port_pkg::ret_t    dc_ret;
	axi_bus_pkg::data_t [BURST_BEATS-1:0] wr_line;
	axi_bus_pkg::ax_req_t ar;
	axi_bus_pkg::ax_req_t aw;
	axi_bus_pkg::r_beat_t r;
	axi_bus_pkg::w_beat_t w;

	// what the last cycle showed
	logic ic_taken, dc_taken, wr_taken, ic_rdy_s, dc_rdy_s;
	cache_port_pkg::ret_t ic_beats[$];
	cache_port_pkg::ret_t dc_beats[$];
	axi_bus_pkg::ax_req_t ar_log[$];
	axi_bus_pkg::ax_req_t aw_log[$];
	axi_bus_pkg::w_beat_t w_log[$];
	int b_count;

	axi_bus_pkg::data_t ref_mem [axi_bus_pkg::addr_t];
	row_t rows [N_ROWS];
	int err_count;
	int tests_passed;

	cache_axi_bridge #(.BURST_BEATS(BURST_BEATS)) dut (
		.clk(clk), .rst(rst),
		.ic_rd_req(ic_rd_req), .ic_rd(ic_rd), .ic_rd_rdy(ic_rd_rdy),
		.ic_ret_valid(ic_ret_valid), .ic_ret(ic_ret),
		.dc_rd_req(dc_rd_req), .dc_rd(dc_rd), .dc_rd_rdy(dc_rd_rdy),
		.dc_ret_valid(dc_ret_valid), .dc_ret(dc_ret),
		.dc_wr_req(dc_wr_req), .dc_wr(dc_wr), .dc_wr_line(wr_line), .dc_wr_rdy(dc_wr_rdy),
		.ar(ar), .arvalid(arvalid), .arready(arready), .r(r), .rvalid(rvalid),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready), .bvalid(bvalid)
	);

	axi_slave_model #(.BURST_BEATS(BURST_BEATS), .SEED(32'hc524cb96)) slave (
		.clk(clk), .rst(rst),
		.ar(ar), .arvalid(arvalid), .arready(arready), .r(r), .rvalid(rvalid),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .overrun(overrun)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, a handshake never completed", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	function automatic axi_bus_pkg::data_t ref_load(input axi_bus_pkg::addr_t a);
		if (ref_mem.exists(a)) return ref_mem[a];
		return a ^ 32'h5a5a0000;
	endfunction

	function automatic void ref_store(input axi_bus_pkg::addr_t a, input axi_bus_pkg::data_t d,
			input axi_bus_pkg::strb_t s);
		axi_bus_pkg::data_t word;
		word = ref_load(a);
		for (int b = 0; b < 4; b++) begin
			if (s[b]) word[8*b +: 8] = d[8*b +: 8];
		end
		ref_mem[a] = word;
	endfunction

	function automatic axi_bus_pkg::data_t line_word(input axi_bus_pkg::data_t d, input int i);
		return d + i * 32'h00010001;
	endfunction

	function automatic axi_bus_pkg::ax_req_t expected_ax(input axi_bus_pkg::axi_id_t id,
			input axi_bus_pkg::addr_t a, input logic unc);
		return '{id: id, addr: a, len: unc ? axi_bus_pkg::len_t'(0)
			: axi_bus_pkg::len_t'(BURST_BEATS - 1), size: 3'd2,
			burst: unc ? axi_bus_pkg::BURST_FIXED : axi_bus_pkg::BURST_INCR};
	endfunction

	task automatic report_error(input string name, input string text);
		err_count++;
		$display("error in %s: %s", name, text);
	endtask

	task automatic check_data(input string name, input axi_bus_pkg::data_t exp,
			input axi_bus_pkg::data_t act);
		if (exp !== act) begin
			err_count++;
			$display("[FAIL] %s data expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_last(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			err_count++;
			$display("[FAIL] %s last expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_ax(input string name, input axi_bus_pkg::ax_req_t exp,
			input axi_bus_pkg::ax_req_t act);
		if (exp !== act) begin
			err_count++;
			$display("[FAIL] %s address beat expected %h actual %h", name, exp, act);
		end
	endtask

	// handshakes sampled before the rising edge and outputs at the falling edge
	task automatic tick();
		#1;
		ic_taken = ic_rd_req && ic_rd_rdy;
		dc_taken = dc_rd_req && dc_rd_rdy;
		wr_taken = dc_wr_req && dc_wr_rdy;
		ic_rdy_s = ic_rd_rdy;
		dc_rdy_s = dc_rd_rdy;
		@(negedge clk);
		if (ic_ret_valid) ic_beats.push_back(ic_ret);
		if (dc_ret_valid) dc_beats.push_back(dc_ret);
		if (arvalid && arready) ar_log.push_back(ar);
		if (awvalid && awready) aw_log.push_back(aw);
		if (wvalid && wready) w_log.push_back(w);
		if (bvalid) b_count++;
	endtask

	task automatic wait_beats(input logic on_ic, input int n);
		while ((on_ic ? ic_beats.size() : dc_beats.size()) < n) tick();
	endtask

	task automatic do_read(input logic on_ic, input axi_bus_pkg::addr_t a, input logic unc);
		cache_port_pkg::rd_req_t req;
		req = '{addr: a, size: 3'd2, uncached: unc};
		ic_rd = req;
		dc_rd = req;
		ic_rd_req = on_ic;
		dc_rd_req = !on_ic;
		do tick(); while (!(on_ic ? ic_taken : dc_taken));
		ic_rd_req = 1'b0;
		dc_rd_req = 1'b0;
		wait_beats(on_ic, unc ? 1 : BURST_BEATS);
	endtask

	task automatic verify_line(input string name, input logic from_ic,
			input axi_bus_pkg::addr_t base, input int n);
		cache_port_pkg::ret_t b;
		for (int i = 0; i < n; i++) begin
			b = from_ic ? ic_beats[i] : dc_beats[i];
			check_data(name, ref_load(base + 4 * i), b.data);
			check_last(name, i == n - 1, b.last);
		end
	endtask

	// returns once the write is taken with the reference memory already updated
	task automatic start_write(input axi_bus_pkg::addr_t a, input logic unc,
			input axi_bus_pkg::data_t d, input axi_bus_pkg::strb_t s);
		dc_wr = '{addr: a, size: 3'd2, strb: s, uncached: unc, word: d};
		for (int i = 0; i < BURST_BEATS; i++) wr_line[i] = line_word(d, i);
		dc_wr_req = 1'b1;
		do tick(); while (!wr_taken);
		dc_wr_req = 1'b0;
		if (unc) ref_store(a, d, s);
		else begin
			for (int i = 0; i < BURST_BEATS; i++) ref_store(a + 4 * i, line_word(d, i), 4'hf);
		end
	endtask

	task automatic check_writes(input string name, input axi_bus_pkg::addr_t a, input logic unc,
			input axi_bus_pkg::data_t d);
		int n;
		n = unc ? 1 : BURST_BEATS;
		while (b_count == 0) tick();
		check_ax(name, expected_ax(axi_bus_pkg::ID_DATA, a, unc), aw_log[0]);
		if (w_log.size() != n) begin
			report_error(name, $sformatf("%0d write beats instead of %0d", w_log.size(), n));
		end else begin
			for (int i = 0; i < n; i++) begin
				check_data(name, unc ? d : line_word(d, i), w_log[i].data);
				check_last(name, i == n - 1, w_log[i].last);
			end
		end
	endtask

	task automatic run_row(input row_t t);
		logic dc_got;
		logic early;
		ic_beats.delete();
		dc_beats.delete();
		ar_log.delete();
		aw_log.delete();
		w_log.delete();
		b_count = 0;
		case (t.kind)
			T_IC_READ, T_DC_READ: begin
				do_read(t.kind == T_IC_READ, t.addr, t.unc);
				verify_line(t.name, t.kind == T_IC_READ, t.addr, t.unc ? 1 : BURST_BEATS);
				check_ax(t.name, expected_ax(t.kind == T_IC_READ ? axi_bus_pkg::ID_INST
					: axi_bus_pkg::ID_DATA, t.addr, t.unc), ar_log[0]);
				if ((t.kind == T_IC_READ ? dc_beats.size() : ic_beats.size()) != 0)
					report_error(t.name, "read data came back on the wrong port");
			end
			T_READ_TIE: begin
				ic_rd = '{addr: t.addr, size: 3'd2, uncached: 1'b0};
				dc_rd = '{addr: t.addr2, size: 3'd2, uncached: 1'b0};
				ic_rd_req = 1'b1;
				dc_rd_req = 1'b1;
				do tick(); while (!ic_taken && !dc_taken);   // both held until one is taken
				if (dc_rdy_s) report_error(t.name, "dc_rd_rdy high while icache also requested");
				ic_rd_req = 1'b0;
				dc_got = dc_taken;
				early = 1'b0;
				while (ic_beats.size() < BURST_BEATS) begin
					tick();
					dc_got = dc_got || dc_taken;
					early = early || (dc_beats.size() != 0);
				end
				if (early) report_error(t.name, "data return before the instruction line ended");
				while (!dc_got) begin
					tick();
					dc_got = dc_taken;
				end
				dc_rd_req = 1'b0;
				wait_beats(1'b0, BURST_BEATS);
				verify_line(t.name, 1'b1, t.addr, BURST_BEATS);
				verify_line(t.name, 1'b0, t.addr2, BURST_BEATS);
				check_ax(t.name, expected_ax(axi_bus_pkg::ID_INST, t.addr, 1'b0), ar_log[0]);
				check_ax(t.name, expected_ax(axi_bus_pkg::ID_DATA, t.addr2, 1'b0), ar_log[1]);
			end
			T_LINE_WRITE, T_WORD_WRITE: begin
				start_write(t.addr, t.unc, t.data, t.strb);
				check_writes(t.name, t.addr, t.unc, t.data);
				dc_beats.delete();
				do_read(1'b0, t.addr, t.unc);
				verify_line(t.name, 1'b0, t.addr, t.unc ? 1 : BURST_BEATS);
			end
			T_WRITE_HOLD: begin
				start_write(t.addr, 1'b0, t.data, 4'hf);
				dc_rd = '{addr: t.addr, size: 3'd2, uncached: 1'b0};
				dc_rd_req = 1'b1;   // left pending across the write
				early = 1'b0;
				while (b_count == 0) begin
					tick();
					early = early || ic_rdy_s || dc_rdy_s || dc_taken;
				end
				if (early) report_error(t.name, "a read port was ready while the write was open");
				do tick(); while (!dc_taken);
				dc_rd_req = 1'b0;
				wait_beats(1'b0, BURST_BEATS);
				verify_line(t.name, 1'b0, t.addr, BURST_BEATS);
			end
			default: report_error(t.name, "unknown row kind");
		endcase
	endtask

	initial begin
		int errs_before;
		rows[0] = '{"ic_line_read", T_IC_READ, 32'h0000_1000, 32'h0, 1'b0, 32'h0, 4'hf};
		rows[1] = '{"dc_uncached_read", T_DC_READ, 32'h0000_2004, 32'h0, 1'b1, 32'h0, 4'hf};
		rows[2] = '{"read_tie", T_READ_TIE, 32'h0000_3000, 32'h0000_4040, 1'b0, 32'h0, 4'hf};
		rows[3] = '{"line_write", T_LINE_WRITE, 32'h0000_5000, 32'h0, 1'b0, 32'hcafe_0000, 4'hf};
		rows[4] = '{"word_write", T_WORD_WRITE, 32'h0000_6008, 32'h0, 1'b1, 32'h1234_abcd, 4'b0101};
		rows[5] = '{"write_hold", T_WRITE_HOLD, 32'h0000_7000, 32'h0, 1'b0, 32'hbeef_0000, 4'hf};
		err_count    = 0;
		tests_passed = 0;
		rst       = 1'b0;
		ic_rd_req = 1'b0;
		dc_rd_req = 1'b0;
		dc_wr_req = 1'b0;
		ic_rd     = '0;
		dc_rd     = '0;
		dc_wr     = '0;
		wr_line   = '0;
		repeat (5) @(negedge clk);
		rst = 1'b1;
		if (arvalid || awvalid || wvalid || !ic_rd_rdy || !dc_rd_rdy || !dc_wr_rdy)
			report_error("reset", "outputs not at their idle values after reset");
		for (int i = 0; i < N_ROWS; i++) begin
			errs_before = err_count;
			run_row(rows[i]);
			if (err_count == errs_before) begin
				tests_passed++;
				$display("test %s: ok", rows[i].name);
			end else begin
				$display("test %s: %0d errors", rows[i].name, err_count - errs_before);
			end
		end
		if (overrun) report_error("slave", "a write burst ran past one cache line");
		$display("tests %0d, passed %0d, failed %0d, errors %0d", N_ROWS, tests_passed,
			N_ROWS - tests_passed, err_count);
		if (err_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* list.f */
hdl/axi_bus_pkg.sv
hdl/cache_port_pkg.sv
hdl/axi_read_engine.sv
hdl/axi_write_engine.sv
hdl/cache_axi_bridge.sv
verif/axi_slave_model.sv
verif/tb_cache_axi_bridge.sv

/* Makefile */
VERILATOR  ?= verilator
TB_TOP     := tb_cache_axi_bridge
RTL_TOP    := cache_axi_bridge
FILELIST   := list.f
LINT_FLAGS := --lint-only -sv --timing --assert
SIM_FLAGS  := --binary -sv --timing --assert
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o sim_$(TB_TOP)
	./$(OBJ_DIR)/sim_$(TB_TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
